//--- design/pool_pkg.sv
// map geometry, widths, credit count, config, control, token and walker state types
`default_nettype none

package pool_pkg;

    // ========================================
    // geometry and widths
    // ========================================
    localparam int unsigned map_len      = 8;
    localparam int unsigned map_bits     = 3;
    localparam int unsigned num_lanes    = 4;
    localparam int unsigned lane_bits    = 2;
    localparam int unsigned psum_width   = 16;
    localparam int unsigned data_width   = 8;
    localparam int unsigned quant_bits   = 7;
    localparam int unsigned max_shift    = psum_width - quant_bits;
    localparam int unsigned shift_width  = 4;
    localparam int unsigned addr_width   = 6;
    // window offset counters, stride up to 4
    localparam int unsigned win_bits     = 2;

    // output flow control
    localparam int unsigned ofm_credits  = 4;
    localparam int unsigned credit_width = 3;

    // ========================================
    // enums
    // ========================================
    typedef enum logic {
        STRIDE_2 = 1'b0,
        STRIDE_4 = 1'b1
    } stride_e;

    typedef enum logic {
        TOK_FLAG  = 1'b0,
        TOK_VALUE = 1'b1
    } tok_kind_e;

    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_READ   = 2'd1,
        SEQ_SETTLE = 2'd2,
        SEQ_HAND   = 2'd3
    } seq_state_e;

    // ========================================
    // bundles
    // ========================================
    typedef struct packed {
        logic [shift_width-1:0] frac_shift;
        stride_e                stride;
    } pool_cfg_t;

    typedef struct packed {
        logic                  en;
        logic [addr_width-1:0] addr;
    } psum_rd_t;

    // one signed partial sum per processing block
    typedef logic signed [num_lanes-1:0][psum_width-1:0] psum_word_t;

    typedef struct packed {
        logic                   clear;
        logic                   sample;
        logic                   commit;
        logic [shift_width-1:0] shift;
    } lane_ctrl_t;

    // flag tokens carry the nonzero mask in the low bits
    typedef struct packed {
        logic                  valid;
        tok_kind_e             kind;
        logic [data_width-1:0] data;
    } ofm_token_t;

endpackage

`default_nettype wire

//--- design/pool_window_seq.sv
// window walker, partial-sum read generation and lane control
`timescale 1ns/1ns
`default_nettype none

module pool_window_seq (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire pool_pkg::pool_cfg_t  cfg,
    input  wire logic                 start,
    input  wire logic                 drain_ready,
    output pool_pkg::psum_rd_t        psum_rd,
    output pool_pkg::lane_ctrl_t      lane_ctrl,
    output logic                      seq_busy
);

    pool_pkg::seq_state_e                  state;
    pool_pkg::seq_state_e                  state_nxt;
    pool_pkg::stride_e                     stride_q;
    logic [pool_pkg::shift_width-1:0]      shift_q;
    logic [pool_pkg::shift_width-1:0]      shift_clamped;
    logic [pool_pkg::addr_width-1:0]       win_base;
    logic [pool_pkg::addr_width-1:0]       next_base;
    logic [pool_pkg::win_bits-1:0]         cnt_x;
    logic [pool_pkg::win_bits-1:0]         cnt_y;
    logic [pool_pkg::win_bits:0]           stride_val;
    logic                                  last_x;
    logic                                  last_y;
    logic                                  row_end;
    logic                                  map_end;
    logic                                  start_acc;
    logic                                  commit;
    logic                                  sample_q;
    logic                                  clear_q;

    // ========================================
    // window geometry
    // ========================================
    always_comb begin
        stride_val = (stride_q == pool_pkg::STRIDE_4) ? 3'd4 : 3'd2;
        last_x     = (cnt_x == pool_pkg::win_bits'(stride_val - 1'b1));
        last_y     = (cnt_y == pool_pkg::win_bits'(stride_val - 1'b1));
        // last window of a row, then last row of the map
        row_end = ((pool_pkg::map_bits+1)'(win_base[pool_pkg::map_bits-1:0])
                   + (pool_pkg::map_bits+1)'(stride_val))
                  == (pool_pkg::map_bits+1)'(pool_pkg::map_len);
        map_end = row_end
                  && (((pool_pkg::map_bits+1)'(win_base[pool_pkg::addr_width-1:pool_pkg::map_bits])
                       + (pool_pkg::map_bits+1)'(stride_val))
                      == (pool_pkg::map_bits+1)'(pool_pkg::map_len));
        // wrapping past the row end already lands one row down
        next_base = win_base + pool_pkg::addr_width'(stride_val);
        if (row_end) begin
            next_base = next_base
                        + (pool_pkg::addr_width'(stride_val - 1'b1) << pool_pkg::map_bits);
        end
    end

    always_comb begin
        shift_clamped = cfg.frac_shift;
        if (cfg.frac_shift > pool_pkg::shift_width'(pool_pkg::max_shift)) begin
            shift_clamped = pool_pkg::shift_width'(pool_pkg::max_shift);
        end
    end

    assign start_acc = start && (state == pool_pkg::SEQ_IDLE);
    assign commit    = (state == pool_pkg::SEQ_HAND) && drain_ready;

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            pool_pkg::SEQ_IDLE: begin
                if (start) begin
                    state_nxt = pool_pkg::SEQ_READ;
                end
            end
            pool_pkg::SEQ_READ: begin
                if (last_x && last_y) begin
                    state_nxt = pool_pkg::SEQ_SETTLE;
                end
            end
            pool_pkg::SEQ_SETTLE: begin
                state_nxt = pool_pkg::SEQ_HAND;
            end
            pool_pkg::SEQ_HAND: begin
                if (drain_ready) begin
                    state_nxt = map_end ? pool_pkg::SEQ_IDLE : pool_pkg::SEQ_READ;
                end
            end
            default: begin
                state_nxt = pool_pkg::SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= pool_pkg::SEQ_IDLE;
            stride_q <= pool_pkg::STRIDE_2;
            shift_q  <= '0;
            win_base <= '0;
            cnt_x    <= '0;
            cnt_y    <= '0;
            sample_q <= 1'b0;
            clear_q  <= 1'b0;
        end else begin
            state    <= state_nxt;
            sample_q <= (state == pool_pkg::SEQ_READ);
            clear_q  <= start_acc;
            case (state)
                pool_pkg::SEQ_IDLE: begin
                    if (start) begin
                        stride_q <= cfg.stride;
                        shift_q  <= shift_clamped;
                        win_base <= '0;
                        cnt_x    <= '0;
                        cnt_y    <= '0;
                    end
                end
                pool_pkg::SEQ_READ: begin
                    // x steps fastest inside the window
                    if (last_x) begin
                        cnt_x <= '0;
                        cnt_y <= last_y ? '0 : cnt_y + 1'b1;
                    end else begin
                        cnt_x <= cnt_x + 1'b1;
                    end
                end
                pool_pkg::SEQ_HAND: begin
                    if (drain_ready && !map_end) begin
                        win_base <= next_base;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ========================================
    // outputs
    // ========================================
    always_comb begin
        psum_rd.en   = (state == pool_pkg::SEQ_READ);
        psum_rd.addr = win_base + pool_pkg::addr_width'(cnt_x)
                       + (pool_pkg::addr_width'(cnt_y) << pool_pkg::map_bits);

        lane_ctrl.clear  = clear_q || commit;
        lane_ctrl.sample = sample_q;
        lane_ctrl.commit = commit;
        lane_ctrl.shift  = shift_q;
    end

    assign seq_busy = (state != pool_pkg::SEQ_IDLE);

endmodule

`default_nettype wire

//--- design/pool_lane.sv
// per-lane ReLU, fixed-point requantization and running max over a window
`timescale 1ns/1ns
`default_nettype none

module pool_lane (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire pool_pkg::lane_ctrl_t                 lane_ctrl,
    input  wire logic signed [pool_pkg::psum_width-1:0] psum,
    output logic [pool_pkg::data_width-1:0]           pooled
);

    logic [pool_pkg::psum_width-1:0] relu_val;
    logic [pool_pkg::psum_width-1:0] shifted;
    logic [pool_pkg::data_width-1:0] quant;

    // negative sums drop to zero
    always_comb begin
        relu_val = psum[pool_pkg::psum_width-1] ? '0 : psum;
        shifted  = relu_val >> lane_ctrl.shift;
        // keep quant_bits above the binary point, top bit stays zero
        quant    = pool_pkg::data_width'(shifted[pool_pkg::quant_bits-1:0]);
    end

    // running max, restarted at every window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pooled <= '0;
        end else if (lane_ctrl.clear) begin
            pooled <= '0;
        end else if (lane_ctrl.sample && (quant > pooled)) begin
            pooled <= quant;
        end
    end

endmodule

`default_nettype wire

//--- design/sparse_drain.sv
// pooled result capture, sparse flag/value token emission and output credit counter
`timescale 1ns/1ns
`default_nettype none

module sparse_drain (
    input  wire logic                                                    clk,
    input  wire logic                                                    rst_n,
    input  wire logic                                                    commit,
    input  wire logic [pool_pkg::num_lanes-1:0][pool_pkg::data_width-1:0] lane_max,
    input  wire logic                                                    seq_busy,
    input  wire logic                                                    credit_return,
    output pool_pkg::ofm_token_t                                         ofm,
    output logic                                                         drain_ready,
    output logic                                                         busy
);

    logic [pool_pkg::num_lanes-1:0][pool_pkg::data_width-1:0] vals_q;
    logic [pool_pkg::num_lanes-1:0]                           cap_mask;
    logic [pool_pkg::num_lanes-1:0]                           mask_q;
    logic [pool_pkg::num_lanes-1:0]                           pend_q;
    logic [pool_pkg::num_lanes-1:0]                           sel_onehot;
    logic [pool_pkg::lane_bits-1:0]                           sel;
    logic [pool_pkg::credit_width-1:0]                        credits_q;
    logic                                                     full_q;
    logic                                                     flag_due_q;
    logic                                                     send;
    logic                                                     last_tok;

    // ========================================
    // capture
    // ========================================
    always_comb begin
        for (int i = 0; i < pool_pkg::num_lanes; i++) begin
            cap_mask[i] = |lane_max[i];
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            vals_q <= lane_max;
        end
    end

    // ========================================
    // token selection
    // ========================================
    // lowest pending lane goes first
    always_comb begin
        sel = '0;
        for (int i = pool_pkg::num_lanes - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                sel = pool_pkg::lane_bits'(i);
            end
        end
        sel_onehot = pool_pkg::num_lanes'(1) << sel;
    end

    always_comb begin
        send = full_q && (credits_q != '0);
        // an all-zero record is the flag alone
        if (flag_due_q) begin
            last_tok = (mask_q == '0);
        end else begin
            last_tok = ((pend_q & ~sel_onehot) == '0);
        end

        ofm.valid = send;
        ofm.kind  = flag_due_q ? pool_pkg::TOK_FLAG : pool_pkg::TOK_VALUE;
        ofm.data  = flag_due_q ? pool_pkg::data_width'(mask_q) : vals_q[sel];
    end

    // ========================================
    // record sequencing
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q     <= 1'b0;
            flag_due_q <= 1'b0;
            mask_q     <= '0;
            pend_q     <= '0;
        end else if (commit) begin
            full_q     <= 1'b1;
            flag_due_q <= 1'b1;
            mask_q     <= cap_mask;
            pend_q     <= cap_mask;
        end else if (send) begin
            if (flag_due_q) begin
                flag_due_q <= 1'b0;
            end else begin
                pend_q <= pend_q & ~sel_onehot;
            end
            if (last_tok) begin
                full_q <= 1'b0;
            end
        end
    end

    // one credit per token, returns add back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= pool_pkg::credit_width'(pool_pkg::ofm_credits);
        end else begin
            case ({send, credit_return})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: begin
                end
            endcase
        end
    end

    assign drain_ready = !full_q;
    assign busy        = seq_busy || full_q;

endmodule

`default_nettype wire

//--- design/pool_top.sv
// pooling stage top with window walker, four pooling lanes and sparse drain
`timescale 1ns/1ns
`default_nettype none

module pool_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire pool_pkg::pool_cfg_t  cfg,
    input  wire logic                 start,
    output pool_pkg::psum_rd_t        psum_rd,
    input  wire pool_pkg::psum_word_t psum_data,
    output pool_pkg::ofm_token_t      ofm,
    input  wire logic                 credit_return,
    output logic                      busy
);

    pool_pkg::lane_ctrl_t                                   lane_ctrl;
    logic [pool_pkg::num_lanes-1:0][pool_pkg::data_width-1:0] lane_max;
    logic                                                   drain_ready;
    logic                                                   seq_busy;

    // ========================================
    // walker
    // ========================================
    pool_window_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .start       (start),
        .drain_ready (drain_ready),
        .psum_rd     (psum_rd),
        .lane_ctrl   (lane_ctrl),
        .seq_busy    (seq_busy)
    );

    // one lane per processing block
    for (genvar i = 0; i < pool_pkg::num_lanes; i++) begin : g_lane
        pool_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .lane_ctrl (lane_ctrl),
            .psum      (psum_data[i]),
            .pooled    (lane_max[i])
        );
    end

    // ========================================
    // output side
    // ========================================
    sparse_drain u_drain (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit        (lane_ctrl.commit),
        .lane_max      (lane_max),
        .seq_busy      (seq_busy),
        .credit_return (credit_return),
        .ofm           (ofm),
        .drain_ready   (drain_ready),
        .busy          (busy)
    );

endmodule

`default_nettype wire

//--- bench/pool_checker.sv
// reference model of reads and sparse tokens, credit and busy checks at the DUT ports
`timescale 1ns/1ns
`default_nettype none

module pool_checker (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire pool_pkg::pool_cfg_t  cfg,
    input  wire logic                 start,
    input  wire logic                 busy,
    input  wire pool_pkg::psum_rd_t   psum_rd,
    input  wire pool_pkg::ofm_token_t ofm,
    input  wire logic                 credit_return,
    input  wire pool_pkg::psum_word_t mem [64],
    output int                        err_count,
    output int                        run_count
);

    int                   errs = 0;
    int                   runs = 0;
    int                   outstanding = 0;
    logic                 run_active = 1'b0;
    logic                 ended = 1'b0;
    int                   exp_addr [$];
    pool_pkg::ofm_token_t exp_tok [$];

    assign err_count = errs;
    assign run_count = runs;

    // ReLU, shift right, keep 7 bits
    function automatic int quant(input logic [15:0] p, input int sh);
        int v;
        v = int'(signed'(p));
        if (v < 0) begin
            v = 0;
        end
        return (v / (1 << sh)) % 128;
    endfunction

    task automatic build_expect(input pool_pkg::pool_cfg_t c);
        int s;
        int sh;
        int a;
        int q;
        int pooled [4];
        logic [3:0] mask;
        s  = (c.stride == pool_pkg::STRIDE_4) ? 4 : 2;
        sh = (int'(c.frac_shift) > 9) ? 9 : int'(c.frac_shift);
        exp_addr.delete();
        exp_tok.delete();
        for (int wy = 0; wy < 8 / s; wy++) begin
            for (int wx = 0; wx < 8 / s; wx++) begin
                pooled = '{0, 0, 0, 0};
                for (int y = 0; y < s; y++) begin
                    for (int x = 0; x < s; x++) begin
                        a = wy * s * 8 + wx * s + x + 8 * y;
                        exp_addr.push_back(a);
                        for (int l = 0; l < 4; l++) begin
                            q = quant(mem[a][l], sh);
                            pooled[l] = (q > pooled[l]) ? q : pooled[l];
                        end
                    end
                end
                for (int l = 0; l < 4; l++) begin
                    mask[l] = (pooled[l] != 0);
                end
                exp_tok.push_back('{valid: 1'b1, kind: pool_pkg::TOK_FLAG, data: {4'b0, mask}});
                for (int l = 0; l < 4; l++) begin
                    if (mask[l]) begin
                        exp_tok.push_back('{valid: 1'b1, kind: pool_pkg::TOK_VALUE,
                                            data: 8'(pooled[l])});
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        pool_pkg::ofm_token_t t;
        int a;
        if (!rst_n) begin
            if (busy) begin
                errs++;
                $display("[%0t] busy is high during reset", $time);
            end
            outstanding = 0;
        end else begin
            // ========================================
            // busy and end of run
            // ========================================
            if (ended) begin
                if (busy) begin
                    errs++;
                    $display("[%0t] busy stayed high after the last token", $time);
                end
                ended = 1'b0;
                run_active = 1'b0;
            end else if (run_active && !busy) begin
                errs++;
                $display("[%0t] busy fell with %0d reads and %0d tokens still expected",
                         $time, exp_addr.size(), exp_tok.size());
                run_active = 1'b0;
                exp_addr.delete();
                exp_tok.delete();
            end
            if (start && !busy) begin
                build_expect(cfg);
                runs++;
                run_active = 1'b1;
            end
            if (psum_rd.en) begin
                if (exp_addr.size() == 0) begin
                    errs++;
                    $display("[%0t] read of address %0d with no read expected", $time,
                             psum_rd.addr);
                end else begin
                    a = exp_addr.pop_front();
                    if (int'(psum_rd.addr) != a) begin
                        errs++;
                        $display("Mismatch at %0t: read address %0d, expected %0d", $time,
                                 psum_rd.addr, a);
                    end
                end
            end
            // ========================================
            // tokens and credits
            // ========================================
            if (ofm.valid) begin
                if (outstanding >= int'(pool_pkg::ofm_credits)) begin
                    errs++;
                    $display("[%0t] token sent while all credits were outstanding", $time);
                end
                if (exp_tok.size() == 0) begin
                    errs++;
                    $display("[%0t] token sent with no token expected", $time);
                end else begin
                    t = exp_tok.pop_front();
                    if (ofm.kind != t.kind || ofm.data != t.data) begin
                        errs++;
                        $display("Mismatch at %0t: token %0d/%02h, expected kind/data %0d/%02h",
                                 $time, ofm.kind, ofm.data, t.kind, t.data);
                    end
                    if (exp_tok.size() == 0 && exp_addr.size() == 0) begin
                        ended = 1'b1;
                    end
                end
                outstanding++;
            end
            if (credit_return) begin
                outstanding--;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/pool_tb.sv
// testbench top with clock, reset, LFSR stimulus, partial-sum buffer, credit returner and tests
`timescale 1ns/1ns
`default_nettype none

module pool_tb;

    // five tests of up to 64 reads, generous cycles per read
    localparam int watchdog_ns = 5 * 64 * 60 * 100;

    logic                 clk;
    logic                 rst_n;
    pool_pkg::pool_cfg_t  cfg;
    logic                 start;
    pool_pkg::psum_rd_t   psum_rd;
    pool_pkg::psum_word_t psum_data = '0;
    pool_pkg::ofm_token_t ofm;
    logic                 credit_return = 1'b0;
    logic                 busy;

    pool_pkg::psum_word_t mem [64];
    logic [15:0]          lfsr = 16'd4;
    logic                 back_pressure = 1'b0;
    int                   ret_q [$];
    int                   now_cyc = 0;
    int                   chk_errs;
    int                   chk_runs;
    int                   tb_errs = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    pool_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .start         (start),
        .psum_rd       (psum_rd),
        .psum_data     (psum_data),
        .ofm           (ofm),
        .credit_return (credit_return),
        .busy          (busy)
    );

    pool_checker u_check (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .start         (start),
        .busy          (busy),
        .psum_rd       (psum_rd),
        .ofm           (ofm),
        .credit_return (credit_return),
        .mem           (mem),
        .err_count     (chk_errs),
        .run_count     (chk_runs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // random numbers
    // ========================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one LFSR step per bit
    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic int return_delay();
        if (back_pressure) begin
            return 20 + (take_bits(5) % 21);
        end
        return take_bits(3);
    endfunction

    task automatic fill_memory();
        logic [15:0] v;
        for (int a = 0; a < 64; a++) begin
            for (int l = 0; l < pool_pkg::num_lanes; l++) begin
                v = 16'(take_bits(16));
                // roughly a third forced below zero
                if (take_bits(3) < 3) begin
                    v[15] = 1'b1;
                end
                mem[a][l] = v;
            end
        end
    endtask

    // ========================================
    // partial-sum buffer and credit returner
    // ========================================
    always @(posedge clk) begin
        if (psum_rd.en) begin
            psum_data <= mem[psum_rd.addr];
        end
    end

    always @(posedge clk or negedge rst_n) begin
        int due;
        if (!rst_n) begin
            credit_return <= 1'b0;
            ret_q.delete();
        end else begin
            now_cyc = now_cyc + 1;
            if (ofm.valid) begin
                due = now_cyc + return_delay();
                // one return per cycle, keep the queue in order
                if (ret_q.size() != 0 && due < ret_q[$]) begin
                    due = ret_q[$];
                end
                ret_q.push_back(due);
            end
            credit_return <= 1'b0;
            if (ret_q.size() != 0 && ret_q[0] <= now_cyc) begin
                void'(ret_q.pop_front());
                credit_return <= 1'b1;
            end
        end
    end

    // ========================================
    // test sequence
    // ========================================
    task automatic pulse_start(input int shift, input logic s4);
        @(posedge clk);
        cfg   <= '{frac_shift: 4'(shift),
                   stride: (s4 ? pool_pkg::STRIDE_4 : pool_pkg::STRIDE_2)};
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (busy);
        while (ret_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic run_test(input string name, input int shift, input logic s4,
                            input logic heavy, input int runs);
        int errs_before;
        int runs_before;
        int errs_now;
        back_pressure = heavy;
        errs_before = tb_errs + chk_errs;
        runs_before = chk_runs;
        for (int r = 0; r < runs; r++) begin
            fill_memory();
            pulse_start(shift, s4);
            if (runs > 1 && r == 0) begin
                repeat (5) @(posedge clk);
                // must be ignored, the walker is mid-run
                pulse_start(0, !s4);
            end
            wait_idle();
        end
        if (chk_runs != runs_before + runs) begin
            tb_errs++;
            $display("test %s: the DUT accepted %0d of %0d start pulses",
                     name, chk_runs - runs_before, runs);
        end
        errs_now = tb_errs + chk_errs - errs_before;
        tests_run++;
        if (errs_now != 0) begin
            tests_failed++;
        end
        $display("test %0d %s, shift %0d: %s, %0d errors", tests_run, name, shift,
                 (errs_now == 0) ? "pass" : "fail", errs_now);
    endtask

    initial begin
        rst_n = 1'b0;
        cfg   = '0;
        start = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        run_test("stride 2", take_bits(4) % 10, 1'b0, 1'b0, 1);
        run_test("stride 4", take_bits(4) % 10, 1'b1, 1'b0, 1);
        run_test("shift above 9", 10 + (take_bits(3) % 6), 1'b0, 1'b0, 1);
        run_test("back-pressure", take_bits(4) % 10, 1'b0, 1'b1, 1);
        run_test("back-to-back", take_bits(4) % 10, 1'b0, 1'b0, 2);
        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, tb_errs + chk_errs);
        if (tb_errs + chk_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/pool_pkg.sv
design/pool_window_seq.sv
design/pool_lane.sv
design/sparse_drain.sv
design/pool_top.sv
bench/pool_checker.sv
bench/pool_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = pool_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
PASS_MSG = NO ERRORS

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
